// ==== id_serialize_patterns.txt ====
# name  slave_id  addr  len  exp_mst_id
# All numbers hex, len is beats minus one, exp_mst_id = (slave_id + 1) mod 4
basic_id00   00 00001000 00 1
basic_id01   01 00002000 01 2
basic_id02   02 00003000 02 3
basic_id03   03 00004000 03 0
basic_id3f   3f 00005000 00 0
limit_a      05 00010000 03 2
limit_b      05 00010100 01 2
limit_c      05 00010200 00 2
limit_d      05 00010300 02 2
limit_e      05 00010400 01 2
same_lane_a  09 00020000 03 2
same_lane_b  0d 00021000 01 2
same_lane_c  09 00022000 00 2
mix_a        10 00030000 07 1
mix_b        21 00031000 02 2
mix_c        12 00032000 05 3
mix_d        14 00033000 01 1
mix_e        23 00034000 00 0
mix_f        10 00035000 03 1
back_a       2a 00040000 0f 3
back_b       2a 00041000 07 3
back_c       07 00042000 04 0
back_d       0b 00043000 02 0
back_e       06 00044000 06 3
back_f       2e 00045000 01 3
wrap_addr    01 fffffffc 03 2
tail_a       30 00050000 00 1
tail_b       31 00051000 00 2

// ==== files.f ====
+incdir+.
axi_rd_pkg.sv
id_ser_pkg.sv
id_ser_ar_demux.sv
id_ser_lane.sv
id_ser_ar_mux.sv
axi_id_serialize_rd.sv
tb_axi_id_serialize.sv

// ==== tb_axi_id_serialize.sv ====
module tb_axi_id_serialize;

  localparam int MAX_PAT = 64;

  logic                clk;
  logic                rst_n;
  axi_rd_pkg::slv_id_t slv_ar_id;
  axi_rd_pkg::addr_t   slv_ar_addr;
  axi_rd_pkg::len_t    slv_ar_len;
  logic                slv_ar_valid;
  logic                slv_ar_ready;
  axi_rd_pkg::slv_id_t slv_r_id;
  axi_rd_pkg::data_t   slv_r_data;
  axi_rd_pkg::resp_e   slv_r_resp;
  logic                slv_r_last;
  logic                slv_r_valid;
  logic                slv_r_ready;
  axi_rd_pkg::mst_id_t mst_ar_id;
  axi_rd_pkg::addr_t   mst_ar_addr;
  axi_rd_pkg::len_t    mst_ar_len;
  logic                mst_ar_valid;
  logic                mst_ar_ready;
  axi_rd_pkg::mst_id_t mst_r_id;
  axi_rd_pkg::data_t   mst_r_data;
  axi_rd_pkg::resp_e   mst_r_resp;
  logic                mst_r_last;
  logic                mst_r_valid;
  logic                mst_r_ready;

  // Pattern table and progress of each burst
  string               pat_name [MAX_PAT];
  axi_rd_pkg::slv_id_t pat_sid  [MAX_PAT];
  axi_rd_pkg::addr_t   pat_addr [MAX_PAT];
  axi_rd_pkg::len_t    pat_len  [MAX_PAT];
  axi_rd_pkg::mst_id_t pat_mid  [MAX_PAT];
  int                  pat_beat [MAX_PAT];
  logic                pat_done [MAX_PAT];
  int                  npat;
  int                  total_beats;
  int                  ar_idx;
  int                  mst_cnt;
  int                  done_cnt;
  int                  cycles;
  int                  limit;
  logic                ar_taken;
  logic                r_taken;
  logic [31:0]         lfsr;

  // Memory slave, accepted bursts waiting for a response
  axi_rd_pkg::mst_id_t mem_id_q   [$];
  axi_rd_pkg::addr_t   mem_addr_q [$];
  axi_rd_pkg::len_t    mem_len_q  [$];
  logic                r_active;
  axi_rd_pkg::addr_t   r_addr;
  int                  r_len;
  int                  r_beat;

  axi_id_serialize_rd dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .slv_ar_id_i    (slv_ar_id),
    .slv_ar_addr_i  (slv_ar_addr),
    .slv_ar_len_i   (slv_ar_len),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_id_o     (slv_r_id),
    .slv_r_data_o   (slv_r_data),
    .slv_r_resp_o   (slv_r_resp),
    .slv_r_last_o   (slv_r_last),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_id_o    (mst_ar_id),
    .mst_ar_addr_o  (mst_ar_addr),
    .mst_ar_len_o   (mst_ar_len),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_id_i     (mst_r_id),
    .mst_r_data_i   (mst_r_data),
    .mst_r_resp_i   (mst_r_resp),
    .mst_r_last_i   (mst_r_last),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready)
  );

  always #50 clk = ~clk;

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("Error: test %0s, %0s expected 0x%0h actual 0x%0h", test, field, expected, actual);
    stop_run();
  endtask

  task automatic report_problem(input string what);
    $display("Failure: %0s", what);
    stop_run();
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] f_sid;
    logic [31:0] f_addr;
    logic [31:0] f_len;
    logic [31:0] f_mid;
    fd = $fopen("id_serialize_patterns.txt", "r");
    assert (fd != 0) else report_problem("cannot open id_serialize_patterns.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Lines starting with a hash are column notes
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h", name, f_sid, f_addr, f_len, f_mid);
        if (n == 5) begin
          assert (npat < MAX_PAT) else report_problem("pattern file holds too many lines");
          pat_name[npat] = name;
          pat_sid[npat]  = axi_rd_pkg::slv_id_t'(f_sid);
          pat_addr[npat] = f_addr;
          pat_len[npat]  = axi_rd_pkg::len_t'(f_len);
          pat_mid[npat]  = axi_rd_pkg::mst_id_t'(f_mid);
          pat_beat[npat] = 0;
          pat_done[npat] = 1'b0;
          total_beats    = total_beats + int'(pat_len[npat]) + 1;
          npat++;
        end
      end
    end
    $fclose(fd);
    assert (npat > 0) else report_problem("pattern file holds no requests");
  endtask

  // Master AR leaves in slave AR order, so the next pattern is the reference
  task automatic check_master_ar();
    int p;
    p = mst_cnt;
    assert (p < npat) else report_problem("master AR seen with no request left to match it");
    assert (mst_ar_id == pat_mid[p])
      else report_mismatch(pat_name[p], "master AR ID", pat_mid[p], mst_ar_id);
    assert (mst_ar_addr == pat_addr[p])
      else report_mismatch(pat_name[p], "master AR addr", pat_addr[p], mst_ar_addr);
    assert (mst_ar_len == pat_len[p])
      else report_mismatch(pat_name[p], "master AR len", pat_len[p], mst_ar_len);
    // Another slave ID on the same lane must have fully returned
    for (int q = 0; q < p; q++) begin
      assert (pat_mid[q] != pat_mid[p] || pat_sid[q] == pat_sid[p] || pat_done[q])
        else report_problem($sformatf("%0s reached master AR before %0s returned its last beat",
                                      pat_name[p], pat_name[q]));
    end
    mem_id_q.push_back(mst_ar_id);
    mem_addr_q.push_back(mst_ar_addr);
    mem_len_q.push_back(mst_ar_len);
    mst_cnt++;
  endtask

  // Oldest open burst on this master ID owns the beat
  task automatic check_slave_r();
    int                p;
    logic              exp_last;
    axi_rd_pkg::data_t exp_data;
    p = -1;
    for (int i = mst_cnt - 1; i >= 0; i--) begin
      if (pat_mid[i] == mst_r_id && !pat_done[i]) begin
        p = i;
      end
    end
    assert (p >= 0)
      else report_problem($sformatf("R beat on master ID %0d with no burst open", mst_r_id));
    exp_data = axi_rd_pkg::data_t'(pat_addr[p] + axi_rd_pkg::addr_t'(pat_beat[p]));
    exp_last = (pat_beat[p] == int'(pat_len[p]));
    assert (slv_r_id == pat_sid[p])
      else report_mismatch(pat_name[p], "slave R ID", pat_sid[p], slv_r_id);
    assert (slv_r_data == exp_data)
      else report_mismatch(pat_name[p], "slave R data", exp_data, slv_r_data);
    assert (slv_r_resp == axi_rd_pkg::OKAY)
      else report_mismatch(pat_name[p], "slave R resp", axi_rd_pkg::OKAY, slv_r_resp);
    assert (slv_r_last == exp_last)
      else report_mismatch(pat_name[p], "slave R last", exp_last, slv_r_last);
    pat_beat[p]++;
    if (exp_last) begin
      pat_done[p] = 1'b1;
      done_cnt++;
    end
  endtask

  // Called at the rising edge, before any register updates
  task automatic sample_handshakes();
    assert (slv_r_valid == mst_r_valid)
      else report_problem("slave R valid does not follow master R valid");
    assert (mst_r_ready == slv_r_ready)
      else report_problem("master R ready does not follow slave R ready");
    if (mst_r_valid && mst_r_ready) begin
      check_slave_r();
      r_taken = 1'b1;
    end
    if (mst_ar_valid && mst_ar_ready) begin
      check_master_ar();
    end
    if (slv_ar_valid && slv_ar_ready) begin
      ar_taken = 1'b1;
      ar_idx++;
    end
  endtask

  // Called at the falling edge
  task automatic drive_inputs();
    logic b0;
    logic b1;
    int   pick;
    if (ar_taken) begin
      slv_ar_valid = 1'b0;
      ar_taken     = 1'b0;
    end
    if (!slv_ar_valid && ar_idx < npat) begin
      slv_ar_id    = pat_sid[ar_idx];
      slv_ar_addr  = pat_addr[ar_idx];
      slv_ar_len   = pat_len[ar_idx];
      slv_ar_valid = 1'b1;
    end
    // Both readies low on one cycle in four
    draw_bit(b0);
    draw_bit(b1);
    mst_ar_ready = b0 | b1;
    draw_bit(b0);
    draw_bit(b1);
    slv_r_ready = b0 | b1;
    if (r_taken) begin
      r_taken     = 1'b0;
      mst_r_valid = 1'b0;
      r_active    = (r_beat != r_len);
      r_beat++;
    end
    // Start a burst after a random delay, preferring a random master ID
    if (!r_active && mem_id_q.size() > 0) begin
      draw_bit(b0);
      if (b0) begin
        draw_bit(b0);
        draw_bit(b1);
        pick = 0;
        for (int i = mem_id_q.size() - 1; i >= 0; i--) begin
          if (mem_id_q[i] == {b1, b0}) begin
            pick = i;
          end
        end
        mst_r_id = mem_id_q[pick];
        r_addr   = mem_addr_q[pick];
        r_len    = int'(mem_len_q[pick]);
        mem_id_q.delete(pick);
        mem_addr_q.delete(pick);
        mem_len_q.delete(pick);
        r_active = 1'b1;
        r_beat   = 0;
      end
    end
    // Gaps between beats too
    if (r_active && !mst_r_valid) begin
      draw_bit(b0);
      if (b0) begin
        mst_r_data  = axi_rd_pkg::data_t'(r_addr + axi_rd_pkg::addr_t'(r_beat));
        mst_r_resp  = axi_rd_pkg::OKAY;
        mst_r_last  = (r_beat == r_len);
        mst_r_valid = 1'b1;
      end
    end
  endtask

  initial begin
    int drain;
    clk          = 1'b0;
    rst_n        = 1'b0;
    slv_ar_id    = '0;
    slv_ar_addr  = '0;
    slv_ar_len   = '0;
    slv_ar_valid = 1'b0;
    slv_r_ready  = 1'b0;
    mst_ar_ready = 1'b0;
    mst_r_id     = '0;
    mst_r_data   = '0;
    mst_r_resp   = axi_rd_pkg::OKAY;
    mst_r_last   = 1'b0;
    mst_r_valid  = 1'b0;
    lfsr         = 32'ha1e9_be6b;
    npat         = 0;
    total_beats  = 0;
    ar_idx       = 0;
    mst_cnt      = 0;
    done_cnt     = 0;
    cycles       = 0;
    ar_taken     = 1'b0;
    r_taken      = 1'b0;
    r_active     = 1'b0;
    drain        = 0;
    load_patterns();
    limit = 40 * total_beats + 200;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    assert (!slv_r_valid && !mst_ar_valid && slv_ar_ready)
      else report_problem("outputs are not idle after reset");
    // Run until every burst is back, then a few quiet cycles for strays
    while (drain < 10) begin
      @(negedge clk);
      drive_inputs();
      @(posedge clk);
      cycles++;
      assert (cycles < limit)
        else report_problem($sformatf("timeout after %0d cycles, %0d of %0d bursts done",
                                      cycles, done_cnt, npat));
      sample_handshakes();
      if (done_cnt == npat) begin
        drain++;
      end
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== axi_id_serialize_rd.sv ====
`include "id_ser_macros.svh"

module axi_id_serialize_rd (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Slave AR
  input  axi_rd_pkg::slv_id_t  slv_ar_id_i,
  input  axi_rd_pkg::addr_t    slv_ar_addr_i,
  input  axi_rd_pkg::len_t     slv_ar_len_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  // Slave R
  output axi_rd_pkg::slv_id_t  slv_r_id_o,
  output axi_rd_pkg::data_t    slv_r_data_o,
  output axi_rd_pkg::resp_e    slv_r_resp_o,
  output logic                 slv_r_last_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  // Master AR
  output axi_rd_pkg::mst_id_t  mst_ar_id_o,
  output axi_rd_pkg::addr_t    mst_ar_addr_o,
  output axi_rd_pkg::len_t     mst_ar_len_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  // Master R
  input  axi_rd_pkg::mst_id_t  mst_r_id_i,
  input  axi_rd_pkg::data_t    mst_r_data_i,
  input  axi_rd_pkg::resp_e    mst_r_resp_i,
  input  logic                 mst_r_last_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o
);

  // Demux to lanes
  axi_rd_pkg::slv_id_t                           dmx_ar_id;
  axi_rd_pkg::addr_t                             dmx_ar_addr;
  axi_rd_pkg::len_t                              dmx_ar_len;
  logic                [`ID_SER_NUM_LANES-1:0]   dmx_ar_valid;
  logic                [`ID_SER_NUM_LANES-1:0]   dmx_ar_ready;
  // Lanes to mux
  axi_rd_pkg::addr_t   [`ID_SER_NUM_LANES-1:0]   lane_ar_addr;
  axi_rd_pkg::len_t    [`ID_SER_NUM_LANES-1:0]   lane_ar_len;
  logic                [`ID_SER_NUM_LANES-1:0]   lane_ar_valid;
  logic                [`ID_SER_NUM_LANES-1:0]   lane_ar_ready;
  // R between mux and lanes, and lanes to slave port
  logic                [`ID_SER_NUM_LANES-1:0]   lane_r_valid;
  logic                [`ID_SER_NUM_LANES-1:0]   lane_r_ready;
  axi_rd_pkg::slv_id_t [`ID_SER_NUM_LANES-1:0]   lane_slv_r_id;
  logic                [`ID_SER_NUM_LANES-1:0]   lane_slv_r_valid;

  id_ser_ar_demux i_ar_demux (
    .clk_i,
    .rst_n_i,
    .slv_ar_id_i,
    .slv_ar_addr_i,
    .slv_ar_len_i,
    .slv_ar_valid_i,
    .slv_ar_ready_o,
    .lane_ar_id_o    (dmx_ar_id),
    .lane_ar_addr_o  (dmx_ar_addr),
    .lane_ar_len_o   (dmx_ar_len),
    .lane_ar_valid_o (dmx_ar_valid),
    .lane_ar_ready_i (dmx_ar_ready)
  );

  for (genvar i = 0; i < `ID_SER_NUM_LANES; i++) begin : gen_lanes
    id_ser_lane i_lane (
      .clk_i,
      .rst_n_i,
      .in_ar_id_i     (dmx_ar_id),
      .in_ar_addr_i   (dmx_ar_addr),
      .in_ar_len_i    (dmx_ar_len),
      .in_ar_valid_i  (dmx_ar_valid[i]),
      .in_ar_ready_o  (dmx_ar_ready[i]),
      .out_ar_addr_o  (lane_ar_addr[i]),
      .out_ar_len_o   (lane_ar_len[i]),
      .out_ar_valid_o (lane_ar_valid[i]),
      .out_ar_ready_i (lane_ar_ready[i]),
      .rsp_r_valid_i  (lane_r_valid[i]),
      .rsp_r_last_i   (mst_r_last_i),
      .rsp_r_ready_o  (lane_r_ready[i]),
      .slv_r_id_o     (lane_slv_r_id[i]),
      .slv_r_valid_o  (lane_slv_r_valid[i]),
      .slv_r_ready_i  (slv_r_ready_i)
    );
  end

  id_ser_ar_mux i_ar_mux (
    .clk_i,
    .rst_n_i,
    .lane_ar_addr_i  (lane_ar_addr),
    .lane_ar_len_i   (lane_ar_len),
    .lane_ar_valid_i (lane_ar_valid),
    .lane_ar_ready_o (lane_ar_ready),
    .mst_ar_id_o,
    .mst_ar_addr_o,
    .mst_ar_len_o,
    .mst_ar_valid_o,
    .mst_ar_ready_i,
    .mst_r_id_i,
    .mst_r_data_i,
    .mst_r_resp_i,
    .mst_r_last_i,
    .mst_r_valid_i,
    .mst_r_ready_o,
    .lane_r_valid_o  (lane_r_valid),
    .lane_r_ready_i  (lane_r_ready),
    .slv_r_data_o,
    .slv_r_resp_o,
    .slv_r_last_o
  );

  // One lane at most presents R, idle lanes drive zero
  always_comb begin
    slv_r_id_o    = '0;
    slv_r_valid_o = 1'b0;
    for (int i = 0; i < `ID_SER_NUM_LANES; i++) begin
      slv_r_id_o    = slv_r_id_o | lane_slv_r_id[i];
      slv_r_valid_o = slv_r_valid_o | lane_slv_r_valid[i];
    end
  end

endmodule

// ==== id_ser_ar_mux.sv ====
`include "id_ser_macros.svh"

module id_ser_ar_mux (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // AR from the lanes
  input  axi_rd_pkg::addr_t [`ID_SER_NUM_LANES-1:0]     lane_ar_addr_i,
  input  axi_rd_pkg::len_t  [`ID_SER_NUM_LANES-1:0]     lane_ar_len_i,
  input  logic              [`ID_SER_NUM_LANES-1:0]     lane_ar_valid_i,
  output logic              [`ID_SER_NUM_LANES-1:0]     lane_ar_ready_o,
  // Master AR channel
  output axi_rd_pkg::mst_id_t                           mst_ar_id_o,
  output axi_rd_pkg::addr_t                             mst_ar_addr_o,
  output axi_rd_pkg::len_t                              mst_ar_len_o,
  output logic                                          mst_ar_valid_o,
  input  logic                                          mst_ar_ready_i,
  // Master R channel
  input  axi_rd_pkg::mst_id_t                           mst_r_id_i,
  input  axi_rd_pkg::data_t                             mst_r_data_i,
  input  axi_rd_pkg::resp_e                             mst_r_resp_i,
  input  logic                                          mst_r_last_i,
  input  logic                                          mst_r_valid_i,
  output logic                                          mst_r_ready_o,
  // R handshake per lane
  output logic              [`ID_SER_NUM_LANES-1:0]     lane_r_valid_o,
  input  logic              [`ID_SER_NUM_LANES-1:0]     lane_r_ready_i,
  // R payload towards the slave port
  output axi_rd_pkg::data_t                             slv_r_data_o,
  output axi_rd_pkg::resp_e                             slv_r_resp_o,
  output logic                                          slv_r_last_o
);

  id_ser_pkg::lane_sel_t rr_q;
  id_ser_pkg::lane_sel_t winner;
  logic                  found;
  logic                  load;
  logic                  grant;
  logic                  valid_q;
  axi_rd_pkg::mst_id_t   id_q;
  axi_rd_pkg::addr_t     addr_q;
  axi_rd_pkg::len_t      len_q;

  // Register free or leaving this cycle
  assign load  = ~valid_q | mst_ar_ready_i;
  assign grant = load & found;

  // Round-robin search, starting at the lane after the last winner
  always_comb begin
    id_ser_pkg::lane_sel_t idx;
    idx    = rr_q;
    winner = rr_q;
    found  = 1'b0;
    for (int k = 0; k < `ID_SER_NUM_LANES; k++) begin
      idx = id_ser_pkg::lane_sel_t'((int'(rr_q) + k) % `ID_SER_NUM_LANES);
      if (!found && lane_ar_valid_i[idx]) begin
        winner = idx;
        found  = 1'b1;
      end
    end
  end

  // Ready only to the winner, and only when the register can load
  always_comb begin
    for (int i = 0; i < `ID_SER_NUM_LANES; i++) begin
      lane_ar_ready_o[i] = grant & (winner == id_ser_pkg::lane_sel_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      rr_q    <= '0;
    end else begin
      if (load) begin
        valid_q <= found;
      end
      // Pointer moves past the lane just served
      if (grant) begin
        rr_q <= id_ser_pkg::lane_sel_t'((int'(winner) + 1) % `ID_SER_NUM_LANES);
      end
    end
  end

  // Lane index becomes the master ID
  always_ff @(posedge clk_i) begin
    if (grant) begin
      id_q   <= axi_rd_pkg::mst_id_t'(winner);
      addr_q <= lane_ar_addr_i[winner];
      len_q  <= lane_ar_len_i[winner];
    end
  end

  assign mst_ar_id_o    = id_q;
  assign mst_ar_addr_o  = addr_q;
  assign mst_ar_len_o   = len_q;
  assign mst_ar_valid_o = valid_q;

  // R decoded by master ID
  always_comb begin
    for (int i = 0; i < `ID_SER_NUM_LANES; i++) begin
      lane_r_valid_o[i] = mst_r_valid_i & (mst_r_id_i == axi_rd_pkg::mst_id_t'(i));
    end
  end

  assign mst_r_ready_o = lane_r_ready_i[mst_r_id_i];

  // Payload needs no steering, only one lane is addressed
  assign slv_r_data_o = mst_r_data_i;
  assign slv_r_resp_o = mst_r_resp_i;
  assign slv_r_last_o = mst_r_last_i;

  // Stalled request holds valid and payload until taken
  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=>
      (mst_ar_valid_o && $stable(mst_ar_id_o) && $stable(mst_ar_addr_o) &&
       $stable(mst_ar_len_o)));

endmodule

// ==== id_ser_lane.sv ====
`include "id_ser_macros.svh"

module id_ser_lane (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // AR from the demux
  input  axi_rd_pkg::slv_id_t  in_ar_id_i,
  input  axi_rd_pkg::addr_t    in_ar_addr_i,
  input  axi_rd_pkg::len_t     in_ar_len_i,
  input  logic                 in_ar_valid_i,
  output logic                 in_ar_ready_o,
  // AR towards the mux, ID dropped
  output axi_rd_pkg::addr_t    out_ar_addr_o,
  output axi_rd_pkg::len_t     out_ar_len_o,
  output logic                 out_ar_valid_o,
  input  logic                 out_ar_ready_i,
  // R steered here by the mux
  input  logic                 rsp_r_valid_i,
  input  logic                 rsp_r_last_i,
  output logic                 rsp_r_ready_o,
  // R towards the slave port, ID restored
  output axi_rd_pkg::slv_id_t  slv_r_id_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i
);

  id_ser_pkg::lane_state_e state_q;
  id_ser_pkg::txn_cnt_t    cnt_q;
  id_ser_pkg::txn_cnt_t    cnt_d;
  axi_rd_pkg::slv_id_t     cur_id_q;
  logic                    admit;
  logic                    ar_fire;
  logic                    r_done;

  // Idle lane takes any ID
  // Busy lane only the owning ID, and only below the burst limit
  assign admit = (state_q == id_ser_pkg::LANE_IDLE) |
                 ((in_ar_id_i == cur_id_q) &
                  (cnt_q < id_ser_pkg::txn_cnt_t'(`ID_SER_MAX_TXNS_PER_ID)));

  // AR path is combinational
  // A blocked request keeps ready low and is not shown downstream
  assign out_ar_addr_o  = in_ar_addr_i;
  assign out_ar_len_o   = in_ar_len_i;
  assign out_ar_valid_o = in_ar_valid_i & admit;
  assign in_ar_ready_o  = admit & out_ar_ready_i;

  assign ar_fire = out_ar_valid_o & out_ar_ready_i;

  // R passes straight through
  assign slv_r_valid_o = rsp_r_valid_i;
  assign rsp_r_ready_o = slv_r_ready_i;

  // ID zero when not presenting, so the top can OR the lanes
  assign slv_r_id_o = rsp_r_valid_i ? cur_id_q : '0;

  // A burst completes on its last accepted beat
  assign r_done = rsp_r_valid_i & rsp_r_ready_o & rsp_r_last_i;

  // Both may happen in one cycle and cancel out
  always_comb begin
    cnt_d = cnt_q;
    if (ar_fire) begin
      cnt_d = cnt_d + id_ser_pkg::txn_cnt_t'(1);
    end
    if (r_done) begin
      cnt_d = cnt_d - id_ser_pkg::txn_cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= '0;
      state_q <= id_ser_pkg::LANE_IDLE;
    end else begin
      cnt_q <= cnt_d;
      // Release the lane once everything has drained
      if (cnt_d == '0) begin
        state_q <= id_ser_pkg::LANE_IDLE;
      end else begin
        state_q <= id_ser_pkg::LANE_BUSY;
      end
    end
  end

  // Owner ID, rewritten by each request it sends
  // While busy only the same ID can pass, so the value holds
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      cur_id_q <= in_ar_id_i;
    end
  end

  // Mux must only route responses to a lane with bursts in flight
  a_no_r_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_r_valid_i |-> (state_q == id_ser_pkg::LANE_BUSY));

  // Admission keeps the count within the limit
  a_cnt_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= id_ser_pkg::txn_cnt_t'(`ID_SER_MAX_TXNS_PER_ID));

endmodule

// ==== id_ser_ar_demux.sv ====
`include "id_ser_macros.svh"

module id_ser_ar_demux (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Slave AR channel
  input  axi_rd_pkg::slv_id_t           slv_ar_id_i,
  input  axi_rd_pkg::addr_t             slv_ar_addr_i,
  input  axi_rd_pkg::len_t              slv_ar_len_i,
  input  logic                          slv_ar_valid_i,
  output logic                          slv_ar_ready_o,
  // Lane side, payload shared, one valid per lane
  output axi_rd_pkg::slv_id_t           lane_ar_id_o,
  output axi_rd_pkg::addr_t             lane_ar_addr_o,
  output axi_rd_pkg::len_t              lane_ar_len_o,
  output logic [`ID_SER_NUM_LANES-1:0]  lane_ar_valid_o,
  input  logic [`ID_SER_NUM_LANES-1:0]  lane_ar_ready_i
);

  id_ser_pkg::lane_sel_t slv_sel;
  id_ser_pkg::lane_sel_t sel_q;
  logic                  valid_q;
  axi_rd_pkg::slv_id_t   id_q;
  axi_rd_pkg::addr_t     addr_q;
  axi_rd_pkg::len_t      len_q;
  logic                  drain;
  logic                  load;

  // Default ID map
  // lane = (id + base offset) mod lane count
  assign slv_sel = id_ser_pkg::lane_sel_t'(
    (int'(slv_ar_id_i) + `ID_SER_BASE_OFFSET) % `ID_SER_NUM_LANES);

  // Stage empties when the selected lane takes the request
  assign drain = valid_q & lane_ar_ready_i[sel_q];

  // Accept into an empty stage or one that drains this cycle
  assign slv_ar_ready_o = ~valid_q | drain;
  assign load           = slv_ar_valid_i & slv_ar_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (drain) begin
      valid_q <= 1'b0;
    end
  end

  // Payload and lane select, held until drained
  always_ff @(posedge clk_i) begin
    if (load) begin
      sel_q  <= slv_sel;
      id_q   <= slv_ar_id_i;
      addr_q <= slv_ar_addr_i;
      len_q  <= slv_ar_len_i;
    end
  end

  assign lane_ar_id_o   = id_q;
  assign lane_ar_addr_o = addr_q;
  assign lane_ar_len_o  = len_q;

  // Only the selected lane sees a valid
  always_comb begin
    for (int i = 0; i < `ID_SER_NUM_LANES; i++) begin
      lane_ar_valid_o[i] = valid_q & (sel_q == id_ser_pkg::lane_sel_t'(i));
    end
  end

  // Never offer one request to two lanes
  a_one_lane: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(lane_ar_valid_o));

endmodule

// ==== id_ser_pkg.sv ====
`include "id_ser_macros.svh"

package id_ser_pkg;

  // Index of one serializer lane
  typedef logic [$clog2(`ID_SER_NUM_LANES)-1:0] lane_sel_t;

  // Lane occupancy
  // Busy means one slave ID owns the lane
  typedef enum logic {
    LANE_IDLE = 1'b0,
    LANE_BUSY = 1'b1
  } lane_state_e;

  // Outstanding bursts of a lane
  // Must reach the limit itself, hence the +1
  typedef logic [$clog2(`ID_SER_MAX_TXNS_PER_ID + 1)-1:0] txn_cnt_t;

endpackage

// ==== axi_rd_pkg.sv ====
`include "id_ser_macros.svh"

package axi_rd_pkg;

  // ID as seen on the slave port
  typedef logic [`ID_SER_SLV_ID_W-1:0] slv_id_t;

  // ID on the master port, equal to the lane number
  typedef logic [`ID_SER_MST_ID_W-1:0] mst_id_t;

  // Byte address of a burst
  typedef logic [`ID_SER_ADDR_W-1:0] addr_t;

  // One beat of read data
  typedef logic [`ID_SER_DATA_W-1:0] data_t;

  // Burst length minus one, as in AXI ARLEN
  typedef logic [`ID_SER_LEN_W-1:0] len_t;

  // RRESP encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

// ==== id_ser_macros.svh ====
`ifndef ID_SER_MACROS_SVH
`define ID_SER_MACROS_SVH

// ID widths on both sides of the serializer
`define ID_SER_SLV_ID_W 6
`define ID_SER_MST_ID_W 2

// One lane per master ID value
`define ID_SER_NUM_LANES 4

// Bursts one lane may have outstanding for its current ID
`define ID_SER_MAX_TXNS_PER_ID 4

// Read channel payload widths
`define ID_SER_ADDR_W 32
`define ID_SER_DATA_W 32
`define ID_SER_LEN_W 8

// Added to the slave ID before the modulo that picks a lane
`define ID_SER_BASE_OFFSET 1

`endif
